// File: hdl/rv_dec_pkg.sv
/*
  Shared widths, RV32I opcode and ALU operation enums,
  sequencer state enum and the decoder port structs
*/
package rv_dec_pkg;

  localparam int XLEN    = 32;
  localparam int REG_AW  = 5;
  localparam int ALU_OPW = 4;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OPC_LOAD    = 7'b0000011,
    OPC_MISCMEM = 7'b0001111,
    OPC_OPIMM   = 7'b0010011,
    OPC_AUIPC   = 7'b0010111,
    OPC_STORE   = 7'b0100011,
    OPC_OP      = 7'b0110011,
    OPC_LUI     = 7'b0110111,
    OPC_BRANCH  = 7'b1100011,
    OPC_JALR    = 7'b1100111,
    OPC_JAL     = 7'b1101111,
    OPC_SYSTEM  = 7'b1110011
  } opcode_e;

  // Encoding is {instr[30], funct3}
  typedef enum logic [ALU_OPW-1:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef enum logic [4:0] {
    S_OK, S_STALL,
    S_LSU_CALC_ADDR, S_LSU_STORE,
    S_LD_CALC_ADDR, S_LD_ISSUE, S_LD_WAIT_0, S_LD_WAIT_1, S_LD_WAIT_2,
    S_BR_CALC_COND, S_BR_CALC_ADDR, S_BR_STALL, S_BR_JUMP, S_BR_STALL_2,
    S_JAL, S_JAL_WAIT_1, S_JAL_WAIT_2,
    S_ILLEGAL, S_IDLE
  } seq_state_e;

  typedef struct packed {
    opcode_e     opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;  // Only bit 5 (instr[30]) matters
  } instr_fields_t;

  typedef struct packed {
    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] s_imm;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] shamt;
    logic [XLEN-1:0] u_imm;  // Already shifted by 12
  } imm_set_t;

  typedef struct packed {
    alu_op_e           op;
    logic              use_pc;   // Operand A is the PC
    logic              op_a_rf;  // Operand A from RF port A
    logic              op_b_rf;  // Operand B from RF port B
    logic              is_imm;
    logic [REG_AW-1:0] dest;
    logic              wb;
    logic [XLEN-1:0]   imm;
  } alu_ctrl_t;

  typedef struct packed {
    logic [REG_AW-1:0] addr_a;
    logic [REG_AW-1:0] addr_b;
  } rf_read_t;

  typedef struct packed {
    logic              valid;
    logic              is_store;
    logic [2:0]        funct3;  // Access size and sign
    logic [REG_AW-1:0] rd;
  } lsu_ctrl_t;

  typedef struct packed {
    logic            valid;         // JAL jump
    logic [XLEN-1:0] addr;
    logic            use_alu_addr;  // Taken branch, target from ALU
  } jmp_ctrl_t;

endpackage

// File: hdl/rv_field_decode.sv
/*
  Instruction field slicing and immediate extraction
  for the I, S, B, J, U and shift-amount formats
*/
module rv_field_decode (
  input  logic [rv_dec_pkg::XLEN-1:0] instr_i,
  output rv_dec_pkg::instr_fields_t   fields_o,
  output rv_dec_pkg::imm_set_t        imm_o
);

  import rv_dec_pkg::*;

  logic sign;

  assign sign = instr_i[31];  // Sign bit of every immediate format

  //////////////////////////////
  // Fields
  //////////////////////////////
  assign fields_o.opcode = opcode_e'(instr_i[6:0]);
  assign fields_o.rd     = instr_i[11:7];
  assign fields_o.funct3 = instr_i[14:12];
  assign fields_o.rs1    = instr_i[19:15];
  assign fields_o.rs2    = instr_i[24:20];
  assign fields_o.funct7 = instr_i[31:25];

  //////////////////////////////
  // Immediates
  //////////////////////////////
  assign imm_o.i_imm = {{(XLEN-12){sign}}, instr_i[31:20]};

  assign imm_o.s_imm = {{(XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};

  // Branch offset, bit 0 always zero
  assign imm_o.b_imm = {{(XLEN-13){sign}}, sign, instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};

  // Jump offset, 21 bits before extension
  assign imm_o.j_imm = {{(XLEN-21){sign}}, sign, instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};

  // ALU takes only the low five bits for shifts
  assign imm_o.shamt = {{(XLEN-5){instr_i[24]}}, instr_i[24:20]};

  assign imm_o.u_imm = {instr_i[31:12], 12'b0};

endmodule

// File: hdl/rv_hazard_unit.sv
/*
  Previous destination tracking and read-after-write detection
*/
module rv_hazard_unit (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  rv_dec_pkg::instr_fields_t fields_i,
  output logic                      hazard_o
);

  import rv_dec_pkg::*;

  logic [REG_AW-1:0] prev_dest;
  logic              uses_rs1;
  logic              uses_rs2;

  // Branches and stores have no destination
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      prev_dest <= '0;
    end else if (fields_i.opcode inside {OPC_BRANCH, OPC_STORE}) begin
      prev_dest <= '0;
    end else begin
      prev_dest <= fields_i.rd;
    end
  end

  // Source registers actually read per opcode
  always_comb begin
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (fields_i.opcode)
      OPC_LOAD, OPC_OPIMM: uses_rs1 = 1'b1;
      OPC_OP, OPC_STORE, OPC_BRANCH: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      default: ;
    endcase
  end

  assign hazard_o = (uses_rs1 && fields_i.rs1 == prev_dest && fields_i.rs1 != '0) ||
                    (uses_rs2 && fields_i.rs2 == prev_dest && fields_i.rs2 != '0);

  // Nothing to wait for right after a branch or store
  a_no_hazard_after_br_st : assert property (@(posedge clk_i) disable iff (!rstn_i)
    (fields_i.opcode inside {OPC_BRANCH, OPC_STORE}) |=> !hazard_o);

endmodule

// File: hdl/rv_seq_ctrl.sv
/*
  Per-opcode sequencing FSM with stall gating, branch resolution,
  JAL target adder and the registered decoder outputs
*/
module rv_seq_ctrl (
  input  logic                        clk_i,
  input  logic                        rstn_i,
  input  logic                        instr_valid_i,
  input  logic [rv_dec_pkg::XLEN-1:0] pc_i,
  input  rv_dec_pkg::instr_fields_t   fields_i,
  input  rv_dec_pkg::imm_set_t        imm_i,
  input  logic                        hazard_i,
  input  logic [rv_dec_pkg::XLEN-1:0] alu_res_i,
  input  logic                        alu_ops_eq_i,
  output logic                        ready_o,
  output logic                        illegal_o,
  output rv_dec_pkg::alu_ctrl_t       alu_o,
  output rv_dec_pkg::rf_read_t        rf_o,
  output rv_dec_pkg::lsu_ctrl_t       lsu_o,
  output rv_dec_pkg::jmp_ctrl_t       jmp_o
);

  import rv_dec_pkg::*;

  seq_state_e      prev_state;
  seq_state_e      curr_state;
  logic            seq_busy;    // Previous state is mid-sequence for this opcode
  logic            take_stall;
  logic            br_taken;
  logic [XLEN-1:0] jal_target;

  logic            ready_d;
  logic            illegal_d;
  alu_ctrl_t       alu_d;
  rf_read_t        rf_d;
  lsu_ctrl_t       lsu_d;
  jmp_ctrl_t       jmp_d;

  //////////////////////////////
  // Stall gating
  //////////////////////////////
  always_comb begin
    case (fields_i.opcode)
      OPC_LOAD:   seq_busy = prev_state inside {S_LD_CALC_ADDR, S_LD_ISSUE,
                                                S_LD_WAIT_0, S_LD_WAIT_1};
      OPC_STORE:  seq_busy = (prev_state == S_LSU_CALC_ADDR);
      OPC_BRANCH: seq_busy = prev_state inside {S_BR_CALC_COND, S_BR_CALC_ADDR,
                                                S_BR_STALL, S_BR_JUMP};
      OPC_JAL:    seq_busy = prev_state inside {S_JAL, S_JAL_WAIT_1};
      default:    seq_busy = 1'b0;
    endcase
  end

  assign take_stall = hazard_i && (prev_state != S_STALL) && !seq_busy;

  //////////////////////////////
  // Branch condition and JAL adder
  //////////////////////////////
  always_comb begin
    case (fields_i.funct3)
      3'b000:         br_taken = alu_ops_eq_i;   // BEQ
      3'b001:         br_taken = !alu_ops_eq_i;  // BNE
      3'b101, 3'b111: br_taken = (alu_res_i == XLEN'(1)) || alu_ops_eq_i;
      default:        br_taken = (alu_res_i == XLEN'(1));
    endcase
  end

  assign jal_target = pc_i + imm_i.j_imm;

  //////////////////////////////
  // Next state and output words
  //////////////////////////////
  always_comb begin
    curr_state = S_IDLE;
    ready_d    = 1'b0;
    illegal_d  = 1'b0;
    alu_d      = '0;
    rf_d       = '0;
    lsu_d      = '0;
    jmp_d      = '0;

    if (!instr_valid_i) begin
      curr_state = S_IDLE;  // Bubble
      ready_d    = 1'b1;
    end else if (take_stall) begin
      curr_state = S_STALL;
    end else begin
      case (fields_i.opcode)
        OPC_OP: begin
          curr_state    = S_OK;
          ready_d       = 1'b1;
          alu_d.op      = alu_op_e'({fields_i.funct7[5], fields_i.funct3});
          alu_d.op_a_rf = 1'b1;
          alu_d.op_b_rf = 1'b1;
          alu_d.dest    = fields_i.rd;
          alu_d.wb      = 1'b1;
          rf_d.addr_a   = fields_i.rs1;
          rf_d.addr_b   = fields_i.rs2;
        end

        OPC_OPIMM: begin
          curr_state    = S_OK;
          ready_d       = 1'b1;
          alu_d.op_a_rf = 1'b1;
          alu_d.is_imm  = 1'b1;
          alu_d.dest    = fields_i.rd;
          alu_d.wb      = 1'b1;
          rf_d.addr_a   = fields_i.rs1;
          if (fields_i.funct3 inside {3'b001, 3'b101}) begin  // Shifts
            alu_d.op  = alu_op_e'({fields_i.funct7[5], fields_i.funct3});
            alu_d.imm = imm_i.shamt;
          end else begin
            alu_d.op  = alu_op_e'({1'b0, fields_i.funct3});
            alu_d.imm = imm_i.i_imm;
          end
        end

        OPC_LUI, OPC_AUIPC: begin  // x0 + imm or pc + imm
          curr_state    = S_OK;
          ready_d       = 1'b1;
          alu_d.op      = ALU_ADD;
          alu_d.use_pc  = (fields_i.opcode == OPC_AUIPC);
          alu_d.op_a_rf = (fields_i.opcode == OPC_LUI);
          alu_d.is_imm  = 1'b1;
          alu_d.dest    = fields_i.rd;
          alu_d.wb      = 1'b1;
          alu_d.imm     = imm_i.u_imm;
        end

        OPC_MISCMEM: begin
          curr_state = S_OK;  // FENCE is a no-op here
          ready_d    = 1'b1;
        end

        OPC_STORE: begin
          rf_d.addr_a = fields_i.rs1;
          rf_d.addr_b = fields_i.rs2;
          if (prev_state == S_LSU_CALC_ADDR) begin
            curr_state     = S_LSU_STORE;
            ready_d        = 1'b1;
            alu_d.op_b_rf  = 1'b1;  // Store data
            lsu_d.valid    = 1'b1;
            lsu_d.is_store = 1'b1;
            lsu_d.funct3   = fields_i.funct3;
          end else begin
            curr_state    = S_LSU_CALC_ADDR;
            alu_d.op      = ALU_ADD;
            alu_d.op_a_rf = 1'b1;
            alu_d.is_imm  = 1'b1;
            alu_d.imm     = imm_i.s_imm;
          end
        end

        OPC_LOAD: begin
          case (prev_state)
            S_LD_CALC_ADDR: begin
              curr_state   = S_LD_ISSUE;
              lsu_d.valid  = 1'b1;
              lsu_d.funct3 = fields_i.funct3;
              lsu_d.rd     = fields_i.rd;
            end
            S_LD_ISSUE:  curr_state = S_LD_WAIT_0;
            S_LD_WAIT_0: curr_state = S_LD_WAIT_1;
            S_LD_WAIT_1: begin
              curr_state = S_LD_WAIT_2;
              ready_d    = 1'b1;
            end
            default: begin
              curr_state    = S_LD_CALC_ADDR;
              alu_d.op      = ALU_ADD;
              alu_d.op_a_rf = 1'b1;
              alu_d.is_imm  = 1'b1;
              alu_d.imm     = imm_i.i_imm;
              rf_d.addr_a   = fields_i.rs1;
            end
          endcase
        end

        OPC_BRANCH: begin
          case (prev_state)
            S_BR_CALC_COND: begin  // Target address pc + offset
              curr_state   = S_BR_CALC_ADDR;
              alu_d.op     = ALU_ADD;
              alu_d.use_pc = 1'b1;
              alu_d.is_imm = 1'b1;
              alu_d.imm    = imm_i.b_imm;
              rf_d.addr_a  = fields_i.rs1;
              rf_d.addr_b  = fields_i.rs2;
            end
            S_BR_CALC_ADDR: begin
              // Compare result is on the ALU feedback now
              curr_state = br_taken ? S_BR_STALL : S_BR_STALL_2;
              ready_d    = !br_taken;
            end
            S_BR_STALL: begin
              curr_state         = S_BR_JUMP;
              jmp_d.use_alu_addr = 1'b1;
            end
            S_BR_JUMP: begin
              curr_state = S_BR_STALL_2;
              ready_d    = 1'b1;
            end
            default: begin
              curr_state    = S_BR_CALC_COND;
              alu_d.op      = fields_i.funct3[1] ? ALU_SLTU : ALU_SLT;
              alu_d.op_a_rf = 1'b1;
              alu_d.op_b_rf = 1'b1;
              // BGE and BGEU compare with swapped operands
              rf_d.addr_a   = fields_i.funct3[0] ? fields_i.rs2 : fields_i.rs1;
              rf_d.addr_b   = fields_i.funct3[0] ? fields_i.rs1 : fields_i.rs2;
            end
          endcase
        end

        OPC_JAL: begin
          alu_d.op     = ALU_ADD;  // rd = pc + 4
          alu_d.use_pc = 1'b1;
          alu_d.is_imm = 1'b1;
          alu_d.imm    = XLEN'(4);
          alu_d.dest   = fields_i.rd;
          alu_d.wb     = 1'b1;
          case (prev_state)
            S_JAL:        curr_state = S_JAL_WAIT_1;
            S_JAL_WAIT_1: begin
              curr_state = S_JAL_WAIT_2;
              ready_d    = 1'b1;
            end
            default: begin
              curr_state = S_JAL;
              jmp_d.valid = 1'b1;
              jmp_d.addr  = jal_target;
            end
          endcase
        end

        default: begin  // JALR, SYSTEM and unknown opcodes
          curr_state = S_ILLEGAL;
          ready_d    = 1'b1;
          illegal_d  = 1'b1;
        end
      endcase
    end
  end

  //////////////////////////////
  // Output registers
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    prev_state <= curr_state;
    ready_o    <= ready_d;
    illegal_o  <= illegal_d;
    alu_o      <= alu_d;
    rf_o       <= rf_d;
    lsu_o      <= lsu_d;
    jmp_o      <= jmp_d;
    if (!rstn_i) begin
      prev_state         <= S_IDLE;
      ready_o            <= 1'b1;
      illegal_o          <= 1'b0;
      alu_o.wb           <= 1'b0;
      lsu_o.valid        <= 1'b0;
      jmp_o.valid        <= 1'b0;
      jmp_o.use_alu_addr <= 1'b0;
    end
  end

  // One LSU request per load or store
  a_lsu_single_pulse : assert property (@(posedge clk_i) disable iff (!rstn_i)
    lsu_o.valid |=> !lsu_o.valid);

  // Fetch must hold the instruction until the sequence ends
  a_not_ready_mid_seq : assert property (@(posedge clk_i) disable iff (!rstn_i)
    (prev_state inside {S_STALL, S_LSU_CALC_ADDR, S_LD_CALC_ADDR, S_LD_ISSUE,
                        S_LD_WAIT_0, S_LD_WAIT_1, S_BR_CALC_COND, S_BR_CALC_ADDR,
                        S_BR_STALL, S_BR_JUMP, S_JAL, S_JAL_WAIT_1}) |-> !ready_o);

endmodule

// File: hdl/rv_decoder.sv
/*
  RV32I multi-cycle decoder top level
*/
module rv_decoder (
  input  logic                        clk_i,
  input  logic                        rstn_i,
  // Fetch unit
  input  logic [rv_dec_pkg::XLEN-1:0] instr_i,
  input  logic [rv_dec_pkg::XLEN-1:0] pc_i,
  input  logic                        instr_valid_i,
  output logic                        ready_o,
  output logic                        illegal_o,
  // ALU feedback for branches
  input  logic [rv_dec_pkg::XLEN-1:0] alu_res_i,
  input  logic                        alu_ops_eq_i,
  // Control outputs
  output rv_dec_pkg::alu_ctrl_t       alu_o,
  output rv_dec_pkg::rf_read_t        rf_o,
  output rv_dec_pkg::lsu_ctrl_t       lsu_o,
  output rv_dec_pkg::jmp_ctrl_t       jmp_o
);

  import rv_dec_pkg::*;

  instr_fields_t fields;
  imm_set_t      imm;
  logic          hazard;

  rv_field_decode u_field_decode (
    .instr_i  (instr_i),
    .fields_o (fields),
    .imm_o    (imm)
  );

  rv_hazard_unit u_hazard_unit (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .fields_i (fields),
    .hazard_o (hazard)
  );

  rv_seq_ctrl u_seq_ctrl (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .pc_i          (pc_i),
    .fields_i      (fields),
    .imm_i         (imm),
    .hazard_i      (hazard),
    .alu_res_i     (alu_res_i),
    .alu_ops_eq_i  (alu_ops_eq_i),
    .ready_o       (ready_o),
    .illegal_o     (illegal_o),
    .alu_o         (alu_o),
    .rf_o          (rf_o),
    .lsu_o         (lsu_o),
    .jmp_o         (jmp_o)
  );

endmodule

// File: testbench/tb_rv_decoder_table.svh
/*
  Decoder stimulus table with expected ALU, LSU, jump and register read words
*/
// Each row gives name, instr, pc, alu_res, ops_eq, link, cycles and pulse cycle
// followed by the expected alu, lsu and jmp words, illegal_o and the register reads
function automatic void load_table();
  // Single-cycle ALU instructions
  add_vec("add x3,x1,x2", 32'h002081b3, 32'h0, 32'h0, 1'b0, L_NEW, 1, 0,
          alu_word(ALU_ADD, 4'b0110, 5'd3, 1'b1, 32'h0), NO_LSU, NO_JMP, 1'b0,
          rf_word(5'd1, 5'd2));
  add_vec("sub x10,x11,x12", 32'h40c58533, 32'h0, 32'h0, 1'b0, L_NEW, 1, 0,
          alu_word(ALU_SUB, 4'b0110, 5'd10, 1'b1, 32'h0), NO_LSU, NO_JMP, 1'b0,
          rf_word(5'd11, 5'd12));
  add_vec("srai x5,x6,3", 32'h40335293, 32'h0, 32'h0, 1'b0, L_NEW, 1, 0,
          alu_word(ALU_SRA, 4'b0101, 5'd5, 1'b1, 32'd3), NO_LSU, NO_JMP, 1'b0,
          rf_word(5'd6, 5'd0));
  add_vec("lui x7,0x12345", 32'h123453b7, 32'h0, 32'h0, 1'b0, L_NEW, 1, 0,
          alu_word(ALU_ADD, 4'b0101, 5'd7, 1'b1, 32'h12345000), NO_LSU, NO_JMP,
          1'b0, NO_RF);
  add_vec("auipc x8,0xfffff", 32'hfffff417, 32'h400, 32'h0, 1'b0, L_NEW, 1, 0,
          alu_word(ALU_ADD, 4'b1001, 5'd8, 1'b1, 32'hfffff000), NO_LSU, NO_JMP,
          1'b0, NO_RF);
  // Store pulses on its last cycle, load on its second
  add_vec("sw x2,8(x1)", 32'h0020a423, 32'h0, 32'h0, 1'b0, L_NEW, 2, 2,
          alu_word(ALU_ADD, 4'b0010, 5'd0, 1'b0, 32'h0),
          lsu_word(1'b1, 1'b1, 3'b010, 5'd0), NO_JMP, 1'b0, rf_word(5'd1, 5'd2));
  add_vec("lw x9,-4(x2)", 32'hffc12483, 32'h0, 32'h0, 1'b0, L_NEW, 5, 2,
          NO_ALU, lsu_word(1'b1, 1'b0, 3'b010, 5'd9), NO_JMP, 1'b0,
          rf_word(5'd2, 5'd0));
  // Branches, taken ones pulse use_alu_addr in cycle 4
  add_vec("beq taken", 32'h00208863, 32'h100, 32'h0, 1'b1, L_NEW, 5, 4,
          NO_ALU, NO_LSU, jmp_word(1'b0, 32'h0, 1'b1), 1'b0, rf_word(5'd1, 5'd2));
  add_vec("beq not taken", 32'h00208863, 32'h100, 32'h0, 1'b0, L_NEW, 3, 0,
          NO_ALU, NO_LSU, NO_JMP, 1'b0, rf_word(5'd1, 5'd2));
  add_vec("bne taken", 32'h00209863, 32'h100, 32'h0, 1'b0, L_NEW, 5, 4,
          NO_ALU, NO_LSU, jmp_word(1'b0, 32'h0, 1'b1), 1'b0, rf_word(5'd2, 5'd1));
  add_vec("bne not taken", 32'h00209863, 32'h100, 32'h0, 1'b1, L_NEW, 3, 0,
          NO_ALU, NO_LSU, NO_JMP, 1'b0, rf_word(5'd2, 5'd1));
  add_vec("blt taken", 32'h0020c863, 32'h100, 32'h1, 1'b0, L_NEW, 5, 4,
          NO_ALU, NO_LSU, jmp_word(1'b0, 32'h0, 1'b1), 1'b0, rf_word(5'd1, 5'd2));
  add_vec("blt not taken", 32'h0020c863, 32'h100, 32'h0, 1'b0, L_NEW, 3, 0,
          NO_ALU, NO_LSU, NO_JMP, 1'b0, rf_word(5'd1, 5'd2));
  add_vec("bge equal taken", 32'h0020d863, 32'h100, 32'h0, 1'b1, L_NEW, 5, 4,
          NO_ALU, NO_LSU, jmp_word(1'b0, 32'h0, 1'b1), 1'b0, rf_word(5'd2, 5'd1));
  // JAL target is pc + J immediate, rd gets pc + 4
  add_vec("jal x1,+256", 32'h100000ef, 32'h1000, 32'h0, 1'b0, L_NEW, 3, 1,
          alu_word(ALU_ADD, 4'b1001, 5'd1, 1'b1, 32'd4), NO_LSU,
          jmp_word(1'b1, 32'h1100, 1'b0), 1'b0, NO_RF);
  add_vec("jal x5,-8", 32'hff9ff2ef, 32'h2000, 32'h0, 1'b0, L_NEW, 3, 1,
          alu_word(ALU_ADD, 4'b1001, 5'd5, 1'b1, 32'd4), NO_LSU,
          jmp_word(1'b1, 32'h1ff8, 1'b0), 1'b0, NO_RF);
  // Read after write on x5, then on x0
  add_vec("add x5,x1,x2", 32'h002082b3, 32'h0, 32'h0, 1'b0, L_NEW, 1, 0,
          alu_word(ALU_ADD, 4'b0110, 5'd5, 1'b1, 32'h0), NO_LSU, NO_JMP, 1'b0,
          rf_word(5'd1, 5'd2));
  add_vec("add x6,x5,x3", 32'h00328333, 32'h0, 32'h0, 1'b0, L_STALL, 2, 0,
          alu_word(ALU_ADD, 4'b0110, 5'd6, 1'b1, 32'h0), NO_LSU, NO_JMP, 1'b0,
          rf_word(5'd5, 5'd3));
  add_vec("add x0,x1,x2", 32'h00208033, 32'h0, 32'h0, 1'b0, L_NEW, 1, 0,
          alu_word(ALU_ADD, 4'b0110, 5'd0, 1'b1, 32'h0), NO_LSU, NO_JMP, 1'b0,
          rf_word(5'd1, 5'd2));
  add_vec("add x7,x0,x3", 32'h003003b3, 32'h0, 32'h0, 1'b0, L_NEXT, 1, 0,
          alu_word(ALU_ADD, 4'b0110, 5'd7, 1'b1, 32'h0), NO_LSU, NO_JMP, 1'b0,
          rf_word(5'd0, 5'd3));
  // Unsupported opcodes
  add_vec("jalr x1,0(x2)", 32'h000100e7, 32'h0, 32'h0, 1'b0, L_NEW, 1, 0,
          NO_ALU, NO_LSU, NO_JMP, 1'b1, NO_RF);
  add_vec("ecall", 32'h00000073, 32'h0, 32'h0, 1'b0, L_NEW, 1, 0,
          NO_ALU, NO_LSU, NO_JMP, 1'b1, NO_RF);
endfunction

// File: testbench/tb_rv_decoder.sv
/*
  Testbench for the RV32I decoder with clock, reset, stimulus loop,
  typed compare tasks and per-test reporting
*/
module tb_rv_decoder;
  timeunit 1ns;
  timeprecision 1ps;

  import rv_dec_pkg::*;

  localparam int        MAX_WAIT = 20;      // Longest sequence is 6 cycles
  localparam logic [1:0] L_NEW   = 2'b00;   // Bubble before the entry
  localparam logic [1:0] L_NEXT  = 2'b01;   // Follows the previous entry directly
  localparam logic [1:0] L_STALL = 2'b11;   // Follows directly, one RAW stall expected
  localparam alu_ctrl_t NO_ALU   = '0;
  localparam lsu_ctrl_t NO_LSU   = '0;
  localparam jmp_ctrl_t NO_JMP   = '0;
  localparam rf_read_t  NO_RF    = '0;

  typedef struct {
    string       name;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] alu_res;
    logic        ops_eq;
    logic        chain;
    logic        stall;
    int          cycles;
    int          pulse;    // Cycle of the LSU or jump pulse, 0 for none
    alu_ctrl_t   alu;      // At the accepting edge
    lsu_ctrl_t   lsu;
    jmp_ctrl_t   jmp;
    logic        illegal;
    rf_read_t    rf;       // First cycle after any stall
  } vec_t;

  logic            clk_i;
  logic            rstn_i;
  logic [XLEN-1:0] instr_i;
  logic [XLEN-1:0] pc_i;
  logic            instr_valid_i;
  logic [XLEN-1:0] alu_res_i;
  logic            alu_ops_eq_i;
  logic            ready_o;
  logic            illegal_o;
  alu_ctrl_t       alu_o;
  rf_read_t        rf_o;
  lsu_ctrl_t       lsu_o;
  jmp_ctrl_t       jmp_o;

  vec_t        vec_q[$];
  logic [31:0] rng = 32'h519d_05db;
  int          test_errs;
  int          errors = 0;
  logic        timed_out = 1'b0;

  rv_decoder DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // src is {use_pc, op_a_rf, op_b_rf, is_imm}
  function automatic alu_ctrl_t alu_word(input alu_op_e op, input logic [3:0] src,
                                         input logic [4:0] dest, input logic wb,
                                         input logic [31:0] imm);
    alu_ctrl_t w;
    w.op = op;
    {w.use_pc, w.op_a_rf, w.op_b_rf, w.is_imm} = src;
    w.dest = dest;
    w.wb   = wb;
    w.imm  = imm;
    return w;
  endfunction

  function automatic lsu_ctrl_t lsu_word(input logic valid, input logic is_store,
                                         input logic [2:0] funct3, input logic [4:0] rd);
    lsu_ctrl_t w;
    w.valid    = valid;
    w.is_store = is_store;
    w.funct3   = funct3;
    w.rd       = rd;
    return w;
  endfunction

  function automatic jmp_ctrl_t jmp_word(input logic valid, input logic [31:0] addr,
                                         input logic use_alu_addr);
    jmp_ctrl_t w;
    w.valid        = valid;
    w.addr         = addr;
    w.use_alu_addr = use_alu_addr;
    return w;
  endfunction

  function automatic rf_read_t rf_word(input logic [4:0] addr_a, input logic [4:0] addr_b);
    rf_read_t w;
    w.addr_a = addr_a;
    w.addr_b = addr_b;
    return w;
  endfunction

  function automatic void add_vec(input string name, input logic [31:0] instr,
                                  input logic [31:0] pc, input logic [31:0] alu_res,
                                  input logic ops_eq, input logic [1:0] link,
                                  input int cycles, input int pulse, input alu_ctrl_t alu,
                                  input lsu_ctrl_t lsu, input jmp_ctrl_t jmp,
                                  input logic illegal, input rf_read_t rf);
    vec_t v;
    v.name    = name;
    v.instr   = instr;
    v.pc      = pc;
    v.alu_res = alu_res;
    v.ops_eq  = ops_eq;
    v.chain   = link[0];
    v.stall   = link[1];
    v.cycles  = cycles;
    v.pulse   = pulse;
    v.alu     = alu;
    v.lsu     = lsu;
    v.jmp     = jmp;
    v.illegal = illegal;
    v.rf      = rf;
    vec_q.push_back(v);
  endfunction

  `include "tb_rv_decoder_table.svh"

  // ADDI with random registers and immediate
  function automatic void add_random_addi(input int n);
    logic [11:0] imm;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    int          i;
    for (i = 0; i < n; i++) begin
      rng = xorshift32(rng);
      rd  = rng[4:0];
      rs1 = rng[9:5];
      imm = rng[21:10];
      add_vec($sformatf("addi x%0d,x%0d,%0d", rd, rs1, $signed(imm)),
              {imm, rs1, 3'b000, rd, 7'b0010011}, 32'h0, 32'h0, 1'b0, L_NEW, 1, 0,
              alu_word(ALU_ADD, 4'b0101, rd, 1'b1, {{20{imm[11]}}, imm}),
              NO_LSU, NO_JMP, 1'b0, rf_word(rs1, 5'd0));
    end
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_alu(input alu_ctrl_t got, input alu_ctrl_t exp, input string what);
    if (got !== exp) begin
      test_errs++;
      $display("ERR @%0d ns: %s alu_o %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_lsu(input lsu_ctrl_t got, input lsu_ctrl_t exp, input string what);
    if (got !== exp) begin
      test_errs++;
      $display("ERR @%0d ns: %s lsu_o %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_jmp(input jmp_ctrl_t got, input jmp_ctrl_t exp, input string what);
    if (got !== exp) begin
      test_errs++;
      $display("ERR @%0d ns: %s jmp_o %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rf(input rf_read_t got, input rf_read_t exp, input string what);
    if (got !== exp) begin
      test_errs++;
      $display("ERR @%0d ns: %s rf_o %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
      test_errs++;
      $display("ERR @%0d ns: %s took %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_illegal(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      test_errs++;
      $display("ERR @%0d ns: %s illegal_o %b, expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // Apply one entry
  //////////////////////////////
  task automatic run_entry(input vec_t v, output int cyc, output logic done);
    lsu_ctrl_t lsu_exp;
    jmp_ctrl_t jmp_exp;
    if (!v.chain) begin
      instr_valid_i = 1'b0;
      instr_i       = '0;  // rd field zero clears prev_dest
      pc_i          = '0;
      alu_res_i     = '0;
      alu_ops_eq_i  = 1'b0;
      @(negedge clk_i);
    end
    instr_valid_i = 1'b1;
    instr_i       = v.instr;
    pc_i          = v.pc;
    alu_res_i     = v.alu_res;
    alu_ops_eq_i  = v.ops_eq;
    cyc  = 0;
    done = 1'b0;
    while (!done && cyc < MAX_WAIT) begin
      @(negedge clk_i);
      cyc++;
      lsu_exp = (cyc == v.pulse) ? v.lsu : NO_LSU;
      jmp_exp = (cyc == v.pulse) ? v.jmp : NO_JMP;
      check_lsu(lsu_o, lsu_exp, v.name);
      check_jmp(jmp_o, jmp_exp, v.name);
      if (v.stall && cyc == 1) begin
        check_alu(alu_o, NO_ALU, {v.name, " stall cycle"});
      end
      if (cyc == (v.stall ? 2 : 1)) begin
        check_rf(rf_o, v.rf, v.name);
      end
      done = ready_o;
    end
    if (done) begin
      check_cycles(cyc, v.cycles, v.name);
      check_alu(alu_o, v.alu, v.name);
      check_illegal(illegal_o, v.illegal, v.name);
    end
  endtask

  initial begin
    int   cyc;
    logic done;
    int   idx;
    int   passed;
    int   failed;
    rstn_i        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    alu_res_i     = '0;
    alu_ops_eq_i  = 1'b0;
    passed        = 0;
    failed        = 0;
    load_table();
    add_random_addi(8);

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;

    idx = 0;
    while (idx < vec_q.size() && !timed_out) begin
      test_errs = 0;
      run_entry(vec_q[idx], cyc, done);
      if (!done) begin
        timed_out = 1'b1;
        $display("Timeout: ready_o stayed low for %0d cycles in test %0d (%s)",
                 MAX_WAIT, idx, vec_q[idx].name);
      end else begin
        errors += test_errs;
        if (test_errs == 0) passed++;
        else failed++;
        $display("test %0d %s: %0d cycle(s), %s", idx, vec_q[idx].name, cyc,
                 (test_errs == 0) ? "ok" : "mismatch");
      end
      idx++;
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             vec_q.size(), passed, failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: rv_decoder.f
+incdir+testbench
hdl/rv_dec_pkg.sv
hdl/rv_field_decode.sv
hdl/rv_hazard_unit.sv
hdl/rv_seq_ctrl.sv
hdl/rv_decoder.sv
testbench/tb_rv_decoder.sv

// File: Makefile
# Verilator flow for the RV32I decoder

TOP   := tb_rv_decoder
FLIST := rv_decoder.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then echo "Failures found in sim.log"; exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
